//--- sram_testchip.f
source/sram_test_pkg.sv
source/scan_shift_reg.sv
source/sram_1rw1r.sv
source/sram_1rw.sv
source/testchip_control.sv
source/sram_testchip.sv
tests/sram_model.sv
tests/tb_sram_testchip.sv

//--- tests/tb_sram_testchip.sv
module tb_sram_testchip
   import sram_test_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   // whole chain, result segment on top
   typedef logic [RES_BITS+CMD_BITS-1:0] chain_t;

   logic clk = 1'b0;
   logic resetn, scan_i, scan_en_i, sram_load_i, global_csb_i;
   logic scan_o, done_o;
   logic [15:0] lfsr_q = 16'd2;
   chain_t exp_chain = '0;
   int checks = 0, errors = 0, tests = 0, failed = 0, test_err = 0;
   int loads = 0, done_cnt = 0;

   sram_testchip sram_testchip_i (
      .clk(clk), .resetn(resetn), .scan_i(scan_i), .scan_en_i(scan_en_i),
      .sram_load_i(sram_load_i), .global_csb_i(global_csb_i), .scan_o(scan_o), .done_o(done_o)
   );

   sram_model model_i ();

   always #4 clk = ~clk;

   // count done pulses mid-cycle
   always @(negedge clk) begin
      if (done_o) done_cnt++;
   end

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // one lfsr step per bit
   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_q[0]};
         lfsr_q = lfsr_next(lfsr_q);
      end
   endtask

   // small address window, bit 7 exercises the single-port aliasing
   task automatic win_addr(output logic [7:0] a);
      logic [31:0] v;
      rand_bits(5, v);
      a = {v[4], 3'b000, v[3:0]};
   endtask

   function automatic mem_cmd_t make_cmd(input logic sel, input logic rd1, input logic web,
         input logic [3:0] mask, input logic [7:0] a0, input logic [7:0] a1,
         input logic [31:0] d);
      mem_cmd_t c;
      c.mem_sel = sel;
      c.rd1_en  = rd1;
      c.web0    = web;
      c.wmask0  = mask;
      c.addr0   = a0;
      c.addr1   = a1;
      c.din0    = d;
      return c;
   endfunction

   // fill data, every address bit shows up
   function automatic logic [31:0] fill_word(input logic [7:0] a, input logic sp);
      return {a ^ 8'hA5, ~a, a, {7'h00, sp} ^ 8'h3C};
   endfunction

   task automatic check(input logic [127:0] got, input logic [127:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic end_test(input string name);
      tests++;
      if (errors == test_err) begin
         $display("test %0d %s: ok", tests, name);
      end else begin
         failed++;
         $display("test %0d %s: FAILED with %0d errors", tests, name, errors - test_err);
      end
      test_err = errors;
   endtask

   // msb first in, old chain collected msb first
   task automatic scan_chain(input chain_t din, output chain_t dout);
      dout = '0;
      scan_en_i = 1'b1;
      for (int i = $bits(chain_t) - 1; i >= 0; i--) begin
         dout = {dout[$bits(chain_t)-2:0], scan_o};
         scan_i = din[i];
         @(posedge clk);
         #1;
      end
      scan_en_i = 1'b0;
      scan_i = 1'b0;
   endtask

   task automatic scan_check(input chain_t din);
      chain_t got;
      scan_chain(din, got);
      check(got, exp_chain, "scan-out chain");
      exp_chain = din;
   endtask

   task automatic wait_done();
      int n;
      n = 0;
      while (!done_o && n < 20) begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!done_o) begin
         $display("done_o did not rise within 20 cycles of a load");
         $display("Simulation finished: FAIL");
         $finish;
      end
   endtask

   // shift in, pulse the load, predict the captured chain
   task automatic run_access(input mem_cmd_t cmd, input logic gcsb);
      mem_res_t res;
      scan_check({{RES_BITS{1'b0}}, cmd});
      check(done_cnt, loads, "done_o pulse count");
      global_csb_i = gcsb;
      sram_load_i = 1'b1;
      @(posedge clk);
      #1;
      sram_load_i = 1'b0;
      loads++;
      wait_done();
      global_csb_i = 1'b0;
      model_i.apply(cmd, gcsb, res);
      exp_chain = {res, cmd};
   endtask

   initial begin
      logic [31:0] v;
      logic [31:0] d;
      logic [7:0]  a0;
      logic [7:0]  a1;
      resetn = 1'b0;
      scan_i = 1'b0;
      scan_en_i = 1'b0;
      sram_load_i = 1'b0;
      global_csb_i = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      resetn = 1'b1;

      // chain is all zero out of reset
      scan_check('0);
      end_test("reset scan-out");

      // dual-port fill, both halves of the window
      for (int a = 0; a < 16; a++) begin
         run_access(make_cmd(1'b0, 1'b0, 1'b0, 4'hF, 8'(a), 8'h00, fill_word(8'(a), 1'b0)), 1'b0);
         run_access(make_cmd(1'b0, 1'b0, 1'b0, 4'hF, 8'(a + 128), 8'h00,
                             fill_word(8'(a + 128), 1'b0)), 1'b0);
      end
      repeat (40) begin
         rand_bits(5, v);
         win_addr(a0);
         rand_bits(32, d);
         run_access(make_cmd(1'b0, 1'b0, v[4], v[4] ? 4'hF : v[3:0], a0, 8'h00, d), 1'b0);
      end
      scan_check('0);
      end_test("dual-port masked writes and reads");

      // port 1 alongside port 0, half on the same address
      repeat (24) begin
         rand_bits(6, v);
         win_addr(a0);
         win_addr(a1);
         rand_bits(32, d);
         run_access(make_cmd(1'b0, 1'b1, v[1], v[5:2], a0, v[0] ? a0 : a1, d), 1'b0);
      end
      scan_check('0);
      end_test("port-1 reads with port-0 writes");

      // single-port fill through random bit 7
      for (int a = 0; a < 16; a++) begin
         rand_bits(1, v);
         a0 = {v[0], 3'b000, 4'(a)};
         run_access(make_cmd(1'b1, 1'b0, 1'b0, 4'hF, a0, 8'h00, fill_word(a0, 1'b1)), 1'b0);
      end
      repeat (30) begin
         rand_bits(7, v);
         win_addr(a0);
         win_addr(a1);
         rand_bits(32, d);
         run_access(make_cmd(v[0], v[1], v[2], v[6:3], a0, a1, d), 1'b0);
      end
      scan_check('0);
      end_test("single-port aliasing and isolation");

      // deselected write, confirming read, deselected read
      repeat (10) begin
         win_addr(a0);
         rand_bits(32, d);
         run_access(make_cmd(1'b0, 1'b1, 1'b0, 4'hF, a0, a0, d), 1'b1);
         run_access(make_cmd(1'b0, 1'b1, 1'b1, 4'hF, a0, a0, d), 1'b0);
         rand_bits(1, v);
         run_access(make_cmd(v[0], 1'b1, 1'b1, 4'hF, a0, 8'h00, d), 1'b1);
      end
      scan_check('0);
      end_test("global chip select");

      // fully mixed commands, readback and done count
      repeat (8) begin
         rand_bits(8, v);
         win_addr(a0);
         win_addr(a1);
         rand_bits(32, d);
         run_access(make_cmd(v[0], v[1], v[2], v[7:4], a0, a1, d), v[3]);
      end
      scan_check('0);
      check(done_cnt, loads, "done_o pulse count");
      end_test("command readback and done pulses");

      $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
               tests, failed, checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

//--- tests/sram_model.sv
module sram_model
   import sram_test_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   // reference arrays, left unknown like the macros
   logic [DATA_W-1:0] dp_mem [0:255];
   logic [DATA_W-1:0] sp_mem [0:127];

   // per-macro read registers, zero after reset
   logic [DATA_W-1:0] dp_dout0 = '0;
   logic [DATA_W-1:0] dp_dout1 = '0;
   logic [DATA_W-1:0] sp_dout0 = '0;

   // byte lanes enabled by the mask take the new data
   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
         input logic [DATA_W-1:0] din, input logic [WMASK_W-1:0] mask);
      logic [DATA_W-1:0] w;
      w = old;
      for (int b = 0; b < WMASK_W; b++) begin
         if (mask[b]) w[8*b +: 8] = din[8*b +: 8];
      end
      return w;
   endfunction

   // one complete access, returns the captured result
   task automatic apply(input mem_cmd_t cmd, input logic gcsb, output mem_res_t res);
      logic [6:0] sp_a;
      sp_a = cmd.addr0[6:0];
      // global deselect leaves arrays and read registers alone
      if (!gcsb && !cmd.mem_sel) begin
         // port 1 sees the word before the write
         if (cmd.rd1_en) dp_dout1 = dp_mem[cmd.addr1];
         if (cmd.web0) dp_dout0 = dp_mem[cmd.addr0];
         else dp_mem[cmd.addr0] = merge_bytes(dp_mem[cmd.addr0], cmd.din0, cmd.wmask0);
      end else if (!gcsb) begin
         if (cmd.web0) sp_dout0 = sp_mem[sp_a];
         else sp_mem[sp_a] = merge_bytes(sp_mem[sp_a], cmd.din0, cmd.wmask0);
      end
      // single-port macro reports zero on dout1
      res.dout0 = cmd.mem_sel ? sp_dout0 : dp_dout0;
      res.dout1 = cmd.mem_sel ? '0 : dp_dout1;
   endtask

endmodule

//--- source/sram_testchip.sv
module sram_testchip
   import sram_test_pkg::*;
(
   input  logic clk,
   input  logic resetn,
   input  logic scan_i,
   input  logic scan_en_i,
   input  logic sram_load_i,
   input  logic global_csb_i,
   output logic scan_o,
   output logic done_o
);

   mem_cmd_t             cmd_scan;
   mem_cmd_t             cmd_q;
   mem_res_t             res_q;
   logic                 capture;
   // link between command and result segments
   logic                 chain_mid;
   logic [DP_ADDR_W-1:0] addr0;
   logic [DATA_W-1:0]    din0;
   logic                 web0;
   logic [WMASK_W-1:0]   wmask0;
   logic [DP_ADDR_W-1:0] addr1;
   logic [NUM_MEMS-1:0]  csb0;
   logic [NUM_MEMS-1:0]  csb1;
   logic [DATA_W-1:0]    dp_dout0;
   logic [DATA_W-1:0]    dp_dout1;
   logic [DATA_W-1:0]    sp_dout0;

   // scan_i -> command segment -> result segment -> scan_o
   scan_shift_reg #(.payload_t(mem_cmd_t)) cmd_seg_i (
      .clk(clk), .resetn(resetn), .shift_i(scan_en_i), .capture_i(capture),
      .ser_i(scan_i), .par_i(cmd_q), .ser_o(chain_mid), .par_o(cmd_scan)
   );

   // results are only read serially
   scan_shift_reg #(.payload_t(mem_res_t)) res_seg_i (
      .clk(clk), .resetn(resetn), .shift_i(scan_en_i), .capture_i(capture),
      .ser_i(chain_mid), .par_i(res_q), .ser_o(scan_o), .par_o()
   );

   testchip_control ctrl_i (
      .clk(clk), .resetn(resetn), .sram_load_i(sram_load_i), .scan_en_i(scan_en_i),
      .global_csb_i(global_csb_i), .cmd_scan_i(cmd_scan), .dp_dout0_i(dp_dout0),
      .dp_dout1_i(dp_dout1), .sp_dout0_i(sp_dout0), .cmd_q_o(cmd_q), .res_q_o(res_q),
      .capture_o(capture), .done_o(done_o), .addr0_o(addr0), .din0_o(din0),
      .web0_o(web0), .wmask0_o(wmask0), .addr1_o(addr1), .csb0_o(csb0), .csb1_o(csb1)
   );

   // 32x256 dual-port macro
   sram_1rw1r #(.ADDR_WIDTH(DP_ADDR_W)) dp_sram_i (
      .clk(clk), .resetn(resetn), .csb0_i(csb0[MEM_DP]), .web0_i(web0),
      .wmask0_i(wmask0), .addr0_i(addr0), .din0_i(din0), .dout0_o(dp_dout0),
      .csb1_i(csb1[MEM_DP]), .addr1_i(addr1), .dout1_o(dp_dout1)
   );

   // 32x128 single-port macro, low address bits only
   sram_1rw #(.ADDR_WIDTH(SP_ADDR_W)) sp_sram_i (
      .clk(clk), .resetn(resetn), .csb0_i(csb0[MEM_SP]), .web0_i(web0),
      .wmask0_i(wmask0), .addr0_i(addr0[SP_ADDR_W-1:0]), .din0_i(din0), .dout0_o(sp_dout0)
   );

endmodule

//--- source/testchip_control.sv
module testchip_control
   import sram_test_pkg::*;
(
   input  logic                 clk,
   input  logic                 resetn,
   input  logic                 sram_load_i,
   input  logic                 scan_en_i,
   input  logic                 global_csb_i,
   input  mem_cmd_t             cmd_scan_i,
   // returned macro data
   input  logic [DATA_W-1:0]    dp_dout0_i,
   input  logic [DATA_W-1:0]    dp_dout1_i,
   input  logic [DATA_W-1:0]    sp_dout0_i,
   output mem_cmd_t             cmd_q_o,
   output mem_res_t             res_q_o,
   output logic                 capture_o,
   output logic                 done_o,
   // shared macro buses
   output logic [DP_ADDR_W-1:0] addr0_o,
   output logic [DATA_W-1:0]    din0_o,
   output logic                 web0_o,
   output logic [WMASK_W-1:0]   wmask0_o,
   output logic [DP_ADDR_W-1:0] addr1_o,
   // active-low selects, one bit per macro
   output logic [NUM_MEMS-1:0]  csb0_o,
   output logic [NUM_MEMS-1:0]  csb1_o
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ACCESS,
      ST_CAPTURE
   } state_t;

   state_t              state_q;
   mem_cmd_t            cmd_q;
   mem_res_t            res_d;
   logic                done_q;
   logic                access_en;
   logic [NUM_MEMS-1:0] sel_oh;

   // load only from idle with the chain at rest
   // a pulse mid-access is dropped
   always_ff @(posedge clk) begin
      if (!resetn) begin
         state_q <= ST_IDLE;
         cmd_q   <= '0;
         done_q  <= 1'b0;
      end else begin
         done_q <= (state_q == ST_CAPTURE);
         case (state_q)
            ST_IDLE: begin
               if (sram_load_i && !scan_en_i) begin
                  cmd_q   <= cmd_scan_i;
                  state_q <= ST_ACCESS;
               end
            end
            // macro edge happens at the end of this cycle
            ST_ACCESS:  state_q <= ST_CAPTURE;
            ST_CAPTURE: state_q <= ST_IDLE;
            default:    state_q <= ST_IDLE;
         endcase
      end
   end

   // selects only during the access cycle, global_csb overrides
   assign access_en = (state_q == ST_ACCESS) && !global_csb_i;
   assign sel_oh    = NUM_MEMS'(1) << cmd_q.mem_sel;
   assign csb0_o    = ~(access_en ? sel_oh : '0);
   // port 1 exists on the dual-port macro only
   assign csb1_o    = ~((access_en && cmd_q.rd1_en) ? (sel_oh & NUM_MEMS'(1 << MEM_DP)) : '0);

   // single-port macro has no dout1
   assign res_d = (cmd_q.mem_sel == MEM_SP) ? {sp_dout0_i, {DATA_W{1'b0}}}
                                            : {dp_dout0_i, dp_dout1_i};

   // scan segment loads the new result on the capture edge
   assign res_q_o   = res_d;
   assign capture_o = (state_q == ST_CAPTURE);
   assign done_o    = done_q;
   assign cmd_q_o   = cmd_q;

   // buses straight from the held command
   assign addr0_o  = cmd_q.addr0;
   assign din0_o   = cmd_q.din0;
   assign web0_o   = cmd_q.web0;
   assign wmask0_o = cmd_q.wmask0;
   assign addr1_o  = cmd_q.addr1;

endmodule

//--- source/sram_1rw.sv
module sram_1rw
   import sram_test_pkg::*;
#(
   parameter int ADDR_WIDTH = SP_ADDR_W
) (
   input  logic                  clk,
   input  logic                  resetn,
   input  logic                  csb0_i,
   input  logic                  web0_i,
   input  logic [WMASK_W-1:0]    wmask0_i,
   input  logic [ADDR_WIDTH-1:0] addr0_i,
   input  logic [DATA_W-1:0]     din0_i,
   output logic [DATA_W-1:0]     dout0_o
);

   localparam int DEPTH = 1 << ADDR_WIDTH;

   logic [DATA_W-1:0] mem [0:DEPTH-1];

   // only enabled byte lanes change
   always_ff @(posedge clk) begin
      if (!csb0_i && !web0_i) begin
         for (int b = 0; b < WMASK_W; b++) begin
            if (wmask0_i[b]) begin
               mem[addr0_i][b*BYTE_W +: BYTE_W] <= din0_i[b*BYTE_W +: BYTE_W];
            end
         end
      end
   end

   // read data register, unchanged on writes and deselect
   always_ff @(posedge clk) begin
      if (!resetn) begin
         dout0_o <= '0;
      end else if (!csb0_i && web0_i) begin
         dout0_o <= mem[addr0_i];
      end
   end

endmodule

//--- source/sram_1rw1r.sv
module sram_1rw1r
   import sram_test_pkg::*;
#(
   parameter int ADDR_WIDTH = DP_ADDR_W
) (
   input  logic                  clk,
   input  logic                  resetn,
   // port 0, read/write
   input  logic                  csb0_i,
   input  logic                  web0_i,
   input  logic [WMASK_W-1:0]    wmask0_i,
   input  logic [ADDR_WIDTH-1:0] addr0_i,
   input  logic [DATA_W-1:0]     din0_i,
   output logic [DATA_W-1:0]     dout0_o,
   // port 1, read only
   input  logic                  csb1_i,
   input  logic [ADDR_WIDTH-1:0] addr1_i,
   output logic [DATA_W-1:0]     dout1_o
);

   localparam int DEPTH = 1 << ADDR_WIDTH;

   logic [DATA_W-1:0] mem [0:DEPTH-1];

   // masked byte write on port 0
   always_ff @(posedge clk) begin
      if (!csb0_i && !web0_i) begin
         for (int b = 0; b < WMASK_W; b++) begin
            if (wmask0_i[b]) begin
               mem[addr0_i][b*BYTE_W +: BYTE_W] <= din0_i[b*BYTE_W +: BYTE_W];
            end
         end
      end
   end

   // registered read data
   // port 1 samples the array before a same-edge write lands
   always_ff @(posedge clk) begin
      if (!resetn) begin
         dout0_o <= '0;
         dout1_o <= '0;
      end else begin
         // dout0 holds during a write
         if (!csb0_i && web0_i) begin
            dout0_o <= mem[addr0_i];
         end
         if (!csb1_i) begin
            dout1_o <= mem[addr1_i];
         end
      end
   end

endmodule

//--- source/scan_shift_reg.sv
module scan_shift_reg #(
   parameter type payload_t = logic [7:0]
) (
   input  logic     clk,
   input  logic     resetn,
   input  logic     shift_i,
   input  logic     capture_i,
   input  logic     ser_i,
   input  payload_t par_i,
   output logic     ser_o,
   output payload_t par_o
);

   // segment length follows the payload
   localparam int W = $bits(payload_t);

   logic [W-1:0] sr_q;

   // capture wins over shift
   // shift in at lsb, data moves toward msb
   always_ff @(posedge clk) begin
      if (!resetn) begin
         sr_q <= '0;
      end else if (capture_i) begin
         sr_q <= par_i;
      end else if (shift_i) begin
         sr_q <= {sr_q[W-2:0], ser_i};
      end
   end

   // msb feeds the next segment
   assign ser_o = sr_q[W-1];

   // parallel view of the segment
   assign par_o = sr_q;

endmodule

//--- source/sram_test_pkg.sv
package sram_test_pkg;

   // data path widths
   localparam int DATA_W    = 32;
   localparam int WMASK_W   = 4;
   // one mask bit per byte lane
   localparam int BYTE_W    = DATA_W / WMASK_W;

   // 32x256 dual-port macro and 32x128 single-port macro
   localparam int DP_ADDR_W = 8;
   localparam int SP_ADDR_W = 7;

   // macro indices into the select buses
   localparam int NUM_MEMS  = 2;
   localparam int MEM_DP    = 0;
   localparam int MEM_SP    = 1;

   // command as it sits in the scan chain, msb first
   typedef struct packed {
      logic                 mem_sel;
      logic                 rd1_en;
      logic                 web0;
      logic [WMASK_W-1:0]   wmask0;
      logic [DP_ADDR_W-1:0] addr0;
      logic [DP_ADDR_W-1:0] addr1;
      logic [DATA_W-1:0]    din0;
   } mem_cmd_t;

   // captured read data, dout0 shifts out first
   typedef struct packed {
      logic [DATA_W-1:0] dout0;
      logic [DATA_W-1:0] dout1;
   } mem_res_t;

   localparam int CMD_BITS = $bits(mem_cmd_t);
   localparam int RES_BITS = $bits(mem_res_t);

endpackage
